// File: compile.f
logic/sld_pkg.sv
logic/sld_sequencer.sv
logic/sld_operand_stage.sv
logic/sld_byte_shift.sv
logic/sld_result_collect.sv
logic/sld_unit.sv
sim/sld_unit_sva.sv
sim/sld_unit_tb.sv

// File: sim/sld_unit_tb.sv
////////////////////////////////////////
// slide unit testbench
// register file model, directed and random slides, write checker
////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module sld_unit_tb;

    import sld_pkg::*;

    localparam int ACK_TIMEOUT = 20;  // cycles
    localparam int WR_TIMEOUT  = 40;

    logic                   clk_i;
    logic                   async_rst_ni;
    logic                   op_rdy;
    logic                   op_ack;
    sld_dir_e               dir;
    vsew_e                  vsew;
    logic [VL_W-1:0]        vl;
    logic [31:0]            rs1;
    logic [REG_A_W-1:0]     vs2;
    logic [REG_A_W-1:0]     vd;
    logic [REG_A_W-1:0]     rd_addr;
    logic [VREG_W-1:0]      rd_data;
    logic                   wr_en;
    logic [REG_A_W-1:0]     wr_addr;
    logic [VREG_W-1:0]      wr_data;
    logic [VREG_BYTES-1:0]  wr_mask;

    logic [VREG_W-1:0]      regfile [32];
    logic [REG_A_W-1:0]     exp_addr_q [$];   // one entry per accepted instruction
    logic [VREG_W-1:0]      exp_data_q [$];
    logic [VREG_BYTES-1:0]  exp_mask_q [$];
    string                  test_name;
    int                     checks;
    int                     errors;
    int                     test_checks0;
    int                     test_errors0;

    initial clk_i = 1'b0;
    always #50 clk_i = ~clk_i;  // 100 ns period

    sld_unit dut0 (
        .clk_i          (clk_i),
        .async_rst_ni   (async_rst_ni),
        .op_rdy_i       (op_rdy),
        .op_ack_o       (op_ack),
        .dir_i          (dir),
        .vsew_i         (vsew),
        .vl_i           (vl),
        .rs1_i          (rs1),
        .vs2_i          (vs2),
        .vd_i           (vd),
        .vreg_rd_addr_o (rd_addr),
        .vreg_rd_i      (rd_data),
        .vreg_wr_en_o   (wr_en),
        .vreg_wr_addr_o (wr_addr),
        .vreg_wr_data_o (wr_data),
        .vreg_wr_mask_o (wr_mask)
    );

    bind sld_unit sld_unit_sva sva0 (
        .clk_i          (clk_i),
        .async_rst_ni   (async_rst_ni),
        .op_rdy_i       (op_rdy_i),
        .op_ack_o       (op_ack_o),
        .vreg_wr_en_o   (vreg_wr_en_o),
        .vreg_wr_mask_o (vreg_wr_mask_o)
    );

    ////////////////////////////////////////
    // register file model

    assign rd_data = regfile[rd_addr];  // answers in the same cycle

    always @(posedge clk_i) begin : regfile_write
        if (wr_en) begin
            for (int b = 0; b < VREG_BYTES; b++) begin
                if (wr_mask[b]) begin
                    regfile[wr_addr][b*8 +: 8] <= wr_data[b*8 +: 8];
                end
            end
        end
    end

    // port rules at the DUT boundary
    always @(posedge clk_i) begin : port_monitor
        if (async_rst_ni === 1'b1) begin
            if ($isunknown(wr_en) || (op_ack && !op_rdy) || (!wr_en && wr_mask != '0)) begin
                $display("ERROR %s: port rule broken (ack %b rdy %b wr_en %b mask %h)",
                         test_name, op_ack, op_rdy, wr_en, wr_mask);
                errors++;
            end
        end
    end

    ////////////////////////////////////////
    // expected results

    function automatic int elem_count(input vsew_e s);
        return VREG_BYTES >> int'(s);
    endfunction

    function automatic void ref_slide(input sld_dir_e d, input vsew_e s,
                                      input logic [VL_W-1:0] v, input logic [31:0] r,
                                      input logic [VREG_W-1:0] src,
                                      output logic [VREG_W-1:0] data,
                                      output logic [VREG_BYTES-1:0] mask);
        int eb;
        int vlb;
        int b;
        eb   = 1 << int'(s);
        vlb  = (int'(v) * eb > VREG_BYTES) ? VREG_BYTES : int'(v) * eb;
        b    = (r >= elem_count(s)) ? VREG_BYTES : int'(r) * eb;  // past the end
        data = '0;
        mask = '0;
        for (int j = 0; j < vlb; j++) begin
            if (d == SLD_UP) begin
                if (j >= b) begin
                    mask[j]        = 1'b1;
                    data[j*8 +: 8] = src[(j-b)*8 +: 8];
                end
            end else begin
                mask[j] = 1'b1;
                if (j + b < VREG_BYTES) begin
                    data[j*8 +: 8] = src[(j+b)*8 +: 8];  // zero beyond the top
                end
            end
        end
    endfunction

    function automatic logic [VREG_W-1:0] byte_mask(input logic [VREG_BYTES-1:0] m);
        logic [VREG_W-1:0] bits;
        for (int j = 0; j < VREG_BYTES; j++) begin
            bits[j*8 +: 8] = {8{m[j]}};
        end
        return bits;
    endfunction

    ////////////////////////////////////////
    // driver and checker

    task automatic send_op(input sld_dir_e d, input vsew_e s, input int v, input logic [31:0] r);
        logic [REG_A_W-1:0]     src_reg;
        logic [REG_A_W-1:0]     dst_reg;
        logic [VREG_W-1:0]      e_data;
        logic [VREG_BYTES-1:0]  e_mask;
        int                     waited;
        src_reg = REG_A_W'($urandom_range(15, 0));   // sources in the low half
        dst_reg = REG_A_W'($urandom_range(31, 16));  // writes never touch a source
        op_rdy <= 1'b1;
        dir    <= d;
        vsew   <= s;
        vl     <= VL_W'(v);
        rs1    <= r;
        vs2    <= src_reg;
        vd     <= dst_reg;
        waited = 0;
        do begin
            @(posedge clk_i);
            waited++;
        end while (!op_ack && waited < ACK_TIMEOUT);
        if (!op_ack) begin
            $display("ERROR %s: no op_ack_o within %0d cycles", test_name, ACK_TIMEOUT);
            errors++;
        end else begin
            ref_slide(d, s, VL_W'(v), r, regfile[src_reg], e_data, e_mask);
            exp_addr_q.push_back(dst_reg);
            exp_data_q.push_back(e_data);
            exp_mask_q.push_back(e_mask);
        end
    endtask

    task automatic collect_writes(input int n);
        int                     waited;
        logic [REG_A_W-1:0]     e_addr;
        logic [VREG_W-1:0]      e_data;
        logic [VREG_BYTES-1:0]  e_mask;
        logic [VREG_W-1:0]      m;
        for (int i = 0; i < n; i++) begin
            waited = 0;
            do begin
                @(posedge clk_i);
                waited++;
            end while (!wr_en && waited < WR_TIMEOUT);
            if (!wr_en) begin
                $display("ERROR %s: write %0d missing after %0d cycles", test_name, i, WR_TIMEOUT);
                errors++;
                return;
            end
            if (exp_addr_q.size() == 0) begin
                $display("ERROR %s: register write with no accepted instruction", test_name);
                errors++;
                continue;
            end
            e_addr = exp_addr_q.pop_front();
            e_data = exp_data_q.pop_front();
            e_mask = exp_mask_q.pop_front();
            m      = byte_mask(e_mask);
            checks++;
            if (wr_addr !== e_addr) begin
                $display("MISMATCH %s addr: expected %h actual %h", test_name, e_addr, wr_addr);
                errors++;
            end
            if (wr_mask !== e_mask) begin
                $display("MISMATCH %s mask: expected %h actual %h", test_name, e_mask, wr_mask);
                errors++;
            end
            if ((wr_data & m) !== e_data) begin
                $display("MISMATCH %s data: expected %h actual %h", test_name, e_data,
                         wr_data & m);
                errors++;
            end
        end
    endtask

    task automatic check_idle(input int cycles);
        for (int i = 0; i < cycles; i++) begin
            @(posedge clk_i);
            if (op_ack !== 1'b0 || wr_en !== 1'b0) begin
                $display("ERROR %s: op_ack_o or vreg_wr_en_o not low while idle", test_name);
                errors++;
            end
        end
    endtask

    task automatic start_test(input string name);
        test_name    = name;
        test_checks0 = checks;
        test_errors0 = errors;
    endtask

    task automatic finish_test();
        if (exp_addr_q.size() != 0) begin
            $display("ERROR %s: %0d accepted instructions never wrote", test_name,
                     exp_addr_q.size());
            errors++;
            exp_addr_q.delete();
            exp_data_q.delete();
            exp_mask_q.delete();
        end
        $display("test %-12s checks %0d errors %0d", test_name, checks - test_checks0,
                 errors - test_errors0);
    endtask

    ////////////////////////////////////////
    // test sequences

    task automatic run_sweep(input sld_dir_e d, input bit short_vl);
        int ne;
        int v;
        fork
            begin
                for (int s = 0; s < 3; s++) begin
                    ne = elem_count(vsew_e'(s));
                    for (int r = 0; r < 4; r++) begin
                        v = short_vl ? int'($urandom_range(ne - 1, 1)) : ne;
                        send_op(d, vsew_e'(s), v, r);
                    end
                end
                op_rdy <= 1'b0;
            end
            collect_writes(12);
        join
    endtask

    task automatic run_large();
        int ne;
        fork
            begin
                for (int s = 0; s < 3; s++) begin
                    ne = elem_count(vsew_e'(s));
                    send_op(SLD_UP, vsew_e'(s), ne, ne);
                    send_op(SLD_DOWN, vsew_e'(s), ne, ne);
                    send_op(SLD_UP, vsew_e'(s), ne, $urandom() | 32'h8000_0000);
                    send_op(SLD_DOWN, vsew_e'(s), ne, $urandom() | 32'h8000_0000);
                end
                op_rdy <= 1'b0;
            end
            collect_writes(12);
        join
    endtask

    task automatic run_random(input int n);
        int ne;
        vsew_e s;
        fork
            begin
                for (int i = 0; i < n; i++) begin
                    s  = vsew_e'($urandom_range(2, 0));
                    ne = elem_count(s);
                    send_op(sld_dir_e'($urandom_range(1, 0)), s, $urandom_range(ne, 0),
                            $urandom_range(ne + 2, 0));
                end
                op_rdy <= 1'b0;
            end
            collect_writes(n);
        join
    endtask

    initial begin : main
        void'($urandom(32'heaf2_9164));
        op_rdy       <= 1'b0;
        dir          <= SLD_UP;
        vsew         <= VSEW_8;
        vl           <= '0;
        rs1          <= '0;
        vs2          <= '0;
        vd           <= '0;
        async_rst_ni <= 1'b0;
        checks = 0;
        errors = 0;
        for (int r = 0; r < 32; r++) begin
            for (int w = 0; w < BEATS; w++) begin
                regfile[r][w*OP_W +: OP_W] = $urandom();
            end
        end

        start_test("reset_idle");
        check_idle(3);  // reset held for 3 cycles
        async_rst_ni <= 1'b1;
        check_idle(6);
        fork
            begin
                send_op(SLD_DOWN, VSEW_8, 16, 1);
                op_rdy <= 1'b0;
            end
            collect_writes(1);
        join
        finish_test();

        start_test("down_small");
        run_sweep(SLD_DOWN, 1'b0);
        finish_test();

        start_test("up_small");
        run_sweep(SLD_UP, 1'b0);
        finish_test();

        start_test("tail_vl");
        run_sweep(SLD_UP, 1'b1);
        run_sweep(SLD_DOWN, 1'b1);
        finish_test();

        start_test("large_rs1");
        run_large();
        finish_test();

        start_test("back_to_back");
        run_random(40);
        check_idle(10);  // no stray write after the last one
        finish_test();

        $display("tests 6 checks %0d errors %0d", checks, errors);
        if (errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: sim/sld_unit_sva.sv
////////////////////////////////////////
// slide unit port assertions
////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module sld_unit_sva (
    input  wire logic                            clk_i,
    input  wire logic                            async_rst_ni,
    input  wire logic                            op_rdy_i,
    input  wire logic                            op_ack_o,
    input  wire logic                            vreg_wr_en_o,
    input  wire logic [sld_pkg::VREG_BYTES-1:0]  vreg_wr_mask_o
);

    // an acknowledge only answers a pending request
    ack_needs_rdy: assert property (
        @(posedge clk_i) disable iff (!async_rst_ni) op_ack_o |-> op_rdy_i
    ) else $error("op_ack_o high without op_rdy_i");

    wr_en_known: assert property (
        @(posedge clk_i) disable iff (!async_rst_ni) !$isunknown(vreg_wr_en_o)
    ) else $error("vreg_wr_en_o is unknown");

    // byte enables only travel with a write
    mask_needs_wr: assert property (
        @(posedge clk_i) disable iff (!async_rst_ni) !vreg_wr_en_o |-> (vreg_wr_mask_o == '0)
    ) else $error("vreg_wr_mask_o set without vreg_wr_en_o");

endmodule

`default_nettype wire

// File: logic/sld_unit.sv
////////////////////////////////////////
// vector slide unit top level
// sequencer, operand, shift and collect stages in a line
////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module sld_unit (
    input  wire logic                            clk_i,
    input  wire logic                            async_rst_ni,

    // instruction handshake
    input  wire logic                            op_rdy_i,
    output logic                                 op_ack_o,
    input  wire sld_pkg::sld_dir_e               dir_i,
    input  wire sld_pkg::vsew_e                  vsew_i,
    input  wire logic [sld_pkg::VL_W-1:0]        vl_i,
    input  wire logic [31:0]                     rs1_i,
    input  wire logic [sld_pkg::REG_A_W-1:0]     vs2_i,
    input  wire logic [sld_pkg::REG_A_W-1:0]     vd_i,

    // register file
    output logic [sld_pkg::REG_A_W-1:0]          vreg_rd_addr_o,
    input  wire logic [sld_pkg::VREG_W-1:0]      vreg_rd_i,
    output logic                                 vreg_wr_en_o,
    output logic [sld_pkg::REG_A_W-1:0]          vreg_wr_addr_o,
    output logic [sld_pkg::VREG_W-1:0]           vreg_wr_data_o,
    output logic [sld_pkg::VREG_BYTES-1:0]       vreg_wr_mask_o
);

    import sld_pkg::*;

    beat_t                seq_beat;
    beat_t                opnd_beat;
    beat_t                shift_beat;
    logic [OP_W-1:0]      op_low;
    logic [OP_W-1:0]      op_high;
    logic                 low_ok;
    logic                 high_ok;
    logic [OP_W-1:0]      result;
    logic [OP_BYTES-1:0]  result_ok;

    sld_sequencer seq0 (
        .clk_i          (clk_i),
        .async_rst_ni   (async_rst_ni),
        .op_rdy_i       (op_rdy_i),
        .op_ack_o       (op_ack_o),
        .dir_i          (dir_i),
        .vsew_i         (vsew_i),
        .vl_i           (vl_i),
        .rs1_i          (rs1_i),
        .vs2_i          (vs2_i),
        .vd_i           (vd_i),
        .vreg_rd_addr_o (vreg_rd_addr_o),
        .beat_o         (seq_beat)
    );

    sld_operand_stage opnd0 (
        .clk_i        (clk_i),
        .async_rst_ni (async_rst_ni),
        .beat_i       (seq_beat),
        .vreg_rd_i    (vreg_rd_i),
        .beat_o       (opnd_beat),
        .op_low_o     (op_low),
        .op_high_o    (op_high),
        .low_ok_o     (low_ok),
        .high_ok_o    (high_ok)
    );

    sld_byte_shift shift0 (
        .clk_i        (clk_i),
        .async_rst_ni (async_rst_ni),
        .beat_i       (opnd_beat),
        .op_low_i     (op_low),
        .op_high_i    (op_high),
        .low_ok_i     (low_ok),
        .high_ok_i    (high_ok),
        .beat_o       (shift_beat),
        .result_o     (result),
        .result_ok_o  (result_ok)
    );

    sld_result_collect coll0 (
        .clk_i          (clk_i),
        .async_rst_ni   (async_rst_ni),
        .beat_i         (shift_beat),
        .result_i       (result),
        .result_ok_i    (result_ok),
        .vreg_wr_en_o   (vreg_wr_en_o),
        .vreg_wr_addr_o (vreg_wr_addr_o),
        .vreg_wr_data_o (vreg_wr_data_o),
        .vreg_wr_mask_o (vreg_wr_mask_o)
    );

endmodule

`default_nettype wire

// File: logic/sld_result_collect.sv
////////////////////////////////////////
// slide result collector
// assembles four chunks, applies the vl tail, writes the register
////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module sld_result_collect (
    input  wire logic                          clk_i,
    input  wire logic                          async_rst_ni,
    input  wire sld_pkg::beat_t                beat_i,
    input  wire logic [sld_pkg::OP_W-1:0]      result_i,
    input  wire logic [sld_pkg::OP_BYTES-1:0]  result_ok_i,
    output logic                               vreg_wr_en_o,
    output logic [sld_pkg::REG_A_W-1:0]        vreg_wr_addr_o,
    output logic [sld_pkg::VREG_W-1:0]         vreg_wr_data_o,
    output logic [sld_pkg::VREG_BYTES-1:0]     vreg_wr_mask_o
);

    import sld_pkg::*;

    logic [OP_BYTES-1:0]    tail_ok;
    logic [VREG_W-1:0]      data_q;    // chunk 0 ends up at the bottom
    logic [VREG_BYTES-1:0]  msk_q;
    logic [REG_A_W-1:0]     addr_q;
    logic                   wr_en_q;

    ////////////////////////////////////////
    // vl tail

    always_comb begin : tail_calc
        logic [VLB_W-1:0] pos;
        for (int k = 0; k < OP_BYTES; k++) begin
            pos        = {2'b00, beat_i.idx, SHIFT_W'(k)};  // byte index in the register
            tail_ok[k] = (pos < beat_i.vl_bytes);
        end
    end

    ////////////////////////////////////////
    // assembly and write

    always_ff @(posedge clk_i) begin
        if (beat_i.valid) begin
            data_q <= {result_i, data_q[VREG_W-1:OP_W]};
            msk_q  <= {result_ok_i & tail_ok, msk_q[VREG_BYTES-1:OP_BYTES]};
        end
        if (beat_i.valid & beat_i.last) begin
            addr_q <= beat_i.vd;
        end
    end

    always_ff @(posedge clk_i or negedge async_rst_ni) begin
        if (!async_rst_ni) begin
            wr_en_q <= 1'b0;
        end else begin
            wr_en_q <= beat_i.valid & beat_i.last;  // one pulse per instruction
        end
    end

    assign vreg_wr_en_o   = wr_en_q;
    assign vreg_wr_addr_o = addr_q;
    assign vreg_wr_data_o = data_q;
    assign vreg_wr_mask_o = wr_en_q ? msk_q : '0;   // buffer is partial between writes

endmodule

`default_nettype wire

// File: logic/sld_byte_shift.sv
////////////////////////////////////////
// slide byte shifter
// picks each result byte from the chunk pair
////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module sld_byte_shift (
    input  wire logic                         clk_i,
    input  wire logic                         async_rst_ni,
    input  wire sld_pkg::beat_t               beat_i,
    input  wire logic [sld_pkg::OP_W-1:0]     op_low_i,
    input  wire logic [sld_pkg::OP_W-1:0]     op_high_i,
    input  wire logic                         low_ok_i,
    input  wire logic                         high_ok_i,
    output sld_pkg::beat_t                    beat_o,
    output logic [sld_pkg::OP_W-1:0]          result_o,
    output logic [sld_pkg::OP_BYTES-1:0]      result_ok_o
);

    import sld_pkg::*;

    logic [OP_W-1:0]      result_d;
    logic [OP_BYTES-1:0]  ok_d;
    logic                 valid_q;
    beat_t                beat_q;

    always_comb begin : byte_sel
        logic [SHIFT_W:0] sel;   // top bit set means the byte comes from the high chunk
        for (int k = 0; k < OP_BYTES; k++) begin
            sel = (SHIFT_W+1)'(k) + {1'b0, beat_i.byte_shift};
            if (sel[SHIFT_W]) begin
                result_d[k*8 +: 8] = op_high_i[sel[SHIFT_W-1:0]*8 +: 8];
                ok_d[k]            = high_ok_i;
            end else begin
                result_d[k*8 +: 8] = op_low_i[sel[SHIFT_W-1:0]*8 +: 8];
                ok_d[k]            = low_ok_i;
            end
        end
    end

    always_ff @(posedge clk_i or negedge async_rst_ni) begin
        if (!async_rst_ni) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= beat_i.valid;
        end
    end

    always_ff @(posedge clk_i) begin
        beat_q      <= beat_i;
        result_o    <= result_d;
        result_ok_o <= ok_d;
    end

    always_comb begin : beat_out
        beat_o       = beat_q;
        beat_o.valid = valid_q;
    end

endmodule

`default_nettype wire

// File: logic/sld_operand_stage.sv
////////////////////////////////////////
// slide operand stage
// holds the source register and picks two chunks per beat
////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module sld_operand_stage (
    input  wire logic                        clk_i,
    input  wire logic                        async_rst_ni,
    input  wire sld_pkg::beat_t              beat_i,
    input  wire logic [sld_pkg::VREG_W-1:0]  vreg_rd_i,
    output sld_pkg::beat_t                   beat_o,
    output logic [sld_pkg::OP_W-1:0]         op_low_o,
    output logic [sld_pkg::OP_W-1:0]         op_high_o,
    output logic                             low_ok_o,
    output logic                             high_ok_o
);

    import sld_pkg::*;

    logic [VREG_W-1:0]  src_q;
    logic [VREG_W-1:0]  src;
    logic [OFF_W:0]     low_idx;   // two's complement, one bit wider than the offset
    logic [OFF_W:0]     high_idx;
    logic               low_in;
    logic               high_in;
    logic [OP_W-1:0]    low_d;
    logic [OP_W-1:0]    high_d;
    logic               valid_q;
    beat_t              beat_q;

    // beat 0 reads the register file directly
    assign src = beat_i.first ? vreg_rd_i : src_q;

    assign low_idx  = {3'b000, beat_i.idx} + {beat_i.chunk_off[OFF_W-1], beat_i.chunk_off};
    assign high_idx = low_idx + 1'b1;
    assign low_in   = (low_idx[OFF_W:IDX_W] == '0);
    assign high_in  = (high_idx[OFF_W:IDX_W] == '0);

    assign low_d  = low_in  ? src[low_idx[IDX_W-1:0]*OP_W +: OP_W]  : '0;
    assign high_d = high_in ? src[high_idx[IDX_W-1:0]*OP_W +: OP_W] : '0;

    always_ff @(posedge clk_i) begin
        if (beat_i.valid & beat_i.first) begin
            src_q <= vreg_rd_i;
        end
    end

    always_ff @(posedge clk_i or negedge async_rst_ni) begin
        if (!async_rst_ni) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= beat_i.valid;
        end
    end

    always_ff @(posedge clk_i) begin
        beat_q    <= beat_i;
        op_low_o  <= low_d;
        op_high_o <= high_d;
        // zero past the end is real data for down, nothing for up
        low_ok_o  <= low_in  | (beat_i.dir == SLD_DOWN);
        high_ok_o <= high_in | (beat_i.dir == SLD_DOWN);
    end

    always_comb begin : beat_out
        beat_o       = beat_q;
        beat_o.valid = valid_q;
    end

endmodule

`default_nettype wire

// File: logic/sld_sequencer.sv
////////////////////////////////////////
// slide sequencer
// takes one instruction, turns rs1 into a byte slide, steps four beats
////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module sld_sequencer (
    input  wire logic                           clk_i,
    input  wire logic                           async_rst_ni,
    input  wire logic                           op_rdy_i,
    output logic                                op_ack_o,
    input  wire sld_pkg::sld_dir_e              dir_i,
    input  wire sld_pkg::vsew_e                 vsew_i,
    input  wire logic [sld_pkg::VL_W-1:0]       vl_i,
    input  wire logic [31:0]                    rs1_i,
    input  wire logic [sld_pkg::REG_A_W-1:0]    vs2_i,
    input  wire logic [sld_pkg::REG_A_W-1:0]    vd_i,
    output logic [sld_pkg::REG_A_W-1:0]         vreg_rd_addr_o,
    output sld_pkg::beat_t                      beat_o
);

    import sld_pkg::*;

    logic                   busy_q;
    logic [IDX_W-1:0]       cnt_q;
    logic                   last_beat;

    // latched command
    sld_dir_e               dir_q;
    logic [OFF_W-1:0]       off_q;
    logic [SHIFT_W-1:0]     shift_q;
    logic [VLB_W-1:0]       vlb_q;
    logic [REG_A_W-1:0]     vs2_q;
    logic [REG_A_W-1:0]     vd_q;

    logic [SLIDE_W-1:0]     byte_slide;
    logic                   slide_ovf;   // rs1 reaches past the register
    logic [VLB_W:0]         vl_prod;
    logic [OFF_W-1:0]       chunk_up;
    logic [OFF_W-1:0]       off_d;
    logic [SHIFT_W-1:0]     shift_d;
    logic [VLB_W-1:0]       vlb_d;

    ////////////////////////////////////////
    // rs1 to byte slide

    always_comb begin : slide_calc
        byte_slide = rs1_i[SLIDE_W-1:0];            // e8
        slide_ovf  = |rs1_i[31:SLIDE_W];
        vl_prod    = {2'b00, vl_i};
        case (vsew_i)
            VSEW_16: begin
                byte_slide = {rs1_i[SLIDE_W-2:0], 1'b0};
                slide_ovf  = |rs1_i[31:SLIDE_W-1];
                vl_prod    = {1'b0, vl_i, 1'b0};
            end
            VSEW_32: begin
                byte_slide = {rs1_i[SLIDE_W-3:0], 2'b00};
                slide_ovf  = |rs1_i[31:SLIDE_W-2];
                vl_prod    = {vl_i, 2'b00};
            end
            default: ;
        endcase
    end

    // vl beyond the register is clamped to the register end
    assign vlb_d = (vl_prod > (VLB_W+1)'(VREG_BYTES)) ? VLB_W'(VREG_BYTES) : vl_prod[VLB_W-1:0];

    // up slides with a partial chunk reach one chunk further back
    assign chunk_up = {2'b00, byte_slide[SLIDE_W-1:SHIFT_W]} + {3'b000, |byte_slide[SHIFT_W-1:0]};

    always_comb begin : split_calc
        if (dir_i == SLD_DOWN) begin
            off_d   = {2'b00, byte_slide[SLIDE_W-1:SHIFT_W]};
            shift_d = byte_slide[SHIFT_W-1:0];
        end else begin
            off_d   = OFF_W'(0) - chunk_up;
            shift_d = SHIFT_W'(0) - byte_slide[SHIFT_W-1:0];
        end
        if (slide_ovf) begin
            // point every chunk outside the register
            off_d   = (dir_i == SLD_DOWN) ? OFF_W'(BEATS) : OFF_W'(0) - OFF_W'(BEATS);
            shift_d = '0;
        end
    end

    ////////////////////////////////////////
    // handshake and beat counter

    assign last_beat = busy_q & (cnt_q == IDX_W'(BEATS - 1));
    assign op_ack_o  = op_rdy_i & (~busy_q | last_beat);  // next op follows without a gap

    always_ff @(posedge clk_i or negedge async_rst_ni) begin
        if (!async_rst_ni) begin
            busy_q <= 1'b0;
            cnt_q  <= '0;
        end else if (op_ack_o) begin
            busy_q <= 1'b1;
            cnt_q  <= '0;
        end else if (busy_q) begin
            busy_q <= ~last_beat;
            cnt_q  <= cnt_q + 1'b1;
        end
    end

    always_ff @(posedge clk_i) begin
        if (op_ack_o) begin
            dir_q   <= dir_i;
            off_q   <= off_d;
            shift_q <= shift_d;
            vlb_q   <= vlb_d;
            vs2_q   <= vs2_i;
            vd_q    <= vd_i;
        end
    end

    assign vreg_rd_addr_o = vs2_q;  // sampled by the operand stage on beat 0

    always_comb begin : beat_build
        beat_o            = '0;
        beat_o.valid      = busy_q;
        beat_o.idx        = cnt_q;
        beat_o.chunk_off  = off_q;
        beat_o.byte_shift = shift_q;
        beat_o.dir        = dir_q;
        beat_o.first      = busy_q & (cnt_q == '0);
        beat_o.last       = last_beat;
        beat_o.vl_bytes   = vlb_q;
        beat_o.vd         = vd_q;
    end

endmodule

`default_nettype wire

// File: logic/sld_pkg.sv
////////////////////////////////////////
// slide unit shared definitions
// register geometry, encodings and the per-beat control word
////////////////////////////////////////

`default_nettype none

package sld_pkg;

    ////////////////////////////////////////
    // geometry

    localparam int unsigned VREG_W     = 128;            // vector register width
    localparam int unsigned VREG_BYTES = VREG_W / 8;     // bytes per register
    localparam int unsigned OP_W       = 32;             // operand chunk width
    localparam int unsigned OP_BYTES   = OP_W / 8;       // bytes per chunk
    localparam int unsigned BEATS      = VREG_W / OP_W;  // chunks per register
    localparam int unsigned VL_W       = 5;              // vl holds 0 to 16

    localparam int unsigned SLIDE_W    = $clog2(VREG_BYTES);  // byte slide amount
    localparam int unsigned SHIFT_W    = $clog2(OP_BYTES);    // sub-chunk byte shift
    localparam int unsigned IDX_W      = $clog2(BEATS);       // beat index
    localparam int unsigned OFF_W      = IDX_W + 2;           // signed chunk offset, -4..4
    localparam int unsigned VLB_W      = 6;                   // vl in bytes
    localparam int unsigned REG_A_W    = 5;                   // register address

    ////////////////////////////////////////
    // encodings

    typedef enum logic {
        SLD_UP   = 1'b0,
        SLD_DOWN = 1'b1
    } sld_dir_e;

    typedef enum logic [1:0] {
        VSEW_8  = 2'b00,
        VSEW_16 = 2'b01,
        VSEW_32 = 2'b10
    } vsew_e;

    ////////////////////////////////////////
    // control word passed from stage to stage

    typedef struct packed {
        logic                     valid;
        logic [IDX_W-1:0]         idx;         // chunk being produced
        logic signed [OFF_W-1:0]  chunk_off;   // source chunk relative to idx
        logic [SHIFT_W-1:0]       byte_shift;  // byte position inside the chunk pair
        sld_dir_e                 dir;
        logic                     first;
        logic                     last;
        logic [VLB_W-1:0]         vl_bytes;    // tail limit
        logic [REG_A_W-1:0]       vd;
    } beat_t;

endpackage

`default_nettype wire
